// File: dv/mon_props.sv
`default_nettype none
`timescale 1ns/1ns

`include "mon_macros.svh"

module mon_props (
        input logic                      aclk,
        input logic                      arst_n,
        input mon_evt_pkg::mon_cfg_t     cfg,
        input mon_bus_pkg::trans_table_t trans_table,
        input logic                      evt_valid,
        input mon_evt_pkg::mon_event_t   evt,
        input logic [`MON_MAX_TRANS-1:0] active_mask
);

        import mon_bus_pkg::*;
        import mon_evt_pkg::*;

        // Failed assertions so far
        int unsigned err_count = 0;

        // Mask one cycle back
        logic [`MON_MAX_TRANS-1:0] mask_q;

        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        mask_q <= '0;
                end else begin
                        mask_q <= active_mask;
                end
        end

        // Quiet during reset and in the first cycle out of it
        a_reset_quiet: assert property (@(posedge aclk)
                !arst_n |-> !evt_valid && active_mask == '0)
        else begin
                $error("outputs active during reset");
                err_count++;
        end

        a_first_cycle: assert property (@(posedge aclk)
                $rose(arst_n) |=> !evt_valid && active_mask == '0)
        else begin
                $error("outputs active in first cycle after reset");
                err_count++;
        end

        // An event only names an entry that was live
        a_evt_was_active: assert property (@(posedge aclk) disable iff (!arst_n)
                evt_valid |-> mask_q[evt.id])
        else begin
                $error("event for an inactive id");
                err_count++;
        end

        a_evt_enabled: assert property (@(posedge aclk) disable iff (!arst_n)
                evt_valid |-> $past(cfg.timeout_enable) && evt.code != EVT_NONE)
        else begin
                $error("event while disabled or with empty code");
                err_count++;
        end

        for (genvar i = 0; i < `MON_MAX_TRANS; i++) begin : g_entry
                // Idle entries hold no stale flags
                a_idle_clean: assert property (@(posedge aclk) disable iff (!arst_n)
                        !trans_table[i].valid |-> trans_table[i] == '0)
                else begin
                        $error("idle entry with flags set");
                        err_count++;
                end

                // Completion and error last one cycle
                a_retire: assert property (@(posedge aclk) disable iff (!arst_n)
                        trans_table[i].state inside {TRANS_COMPLETE, TRANS_ERROR}
                        |=> trans_table[i] == '0)
                else begin
                        $error("entry not retired after one cycle");
                        err_count++;
                end
        end

endmodule

bind mon_top mon_props i_mon_props (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .cfg         (cfg),
        .trans_table (trans_table),
        .evt_valid   (evt_valid),
        .evt         (evt),
        .active_mask (active_mask)
);

`default_nettype wire

// File: dv/mon_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "mon_macros.svh"

module mon_tb;

        import mon_bus_pkg::*;
        import mon_evt_pkg::*;

        localparam int          HALF_PERIOD = 2;
        localparam int          RST_CYCLES  = 4;
        localparam int          MARGIN      = 16;
        localparam int          SETTLE      = 8;
        localparam logic [16:0] SEED        = 17'd94333;
        // Galois taps for x^17 + x^14 + 1
        localparam logic [16:0] TAPS        = 17'h12000;

        logic                      aclk;
        logic                      arst_n;
        axi_wr_obs_t               obs;
        mon_cfg_t                  cfg;
        logic                      evt_valid;
        mon_event_t                evt;
        logic [`MON_MAX_TRANS-1:0] active_mask;

        // Events still owed by the DUT, oldest first
        mon_event_t                exp_q [$];
        string                     test_name;
        logic [16:0]               lfsr;
        logic [`MON_TIMER_W-1:0]   thr_cmd;
        logic [`MON_TIMER_W-1:0]   thr_dr;
        logic [`MON_TIMER_W-1:0]   thr_off;
        int                        total_budget;
        logic                      budget_ready;

        mon_top i_mon_top (
                .aclk        (aclk),
                .arst_n      (arst_n),
                .obs         (obs),
                .cfg         (cfg),
                .evt_valid   (evt_valid),
                .evt         (evt),
                .active_mask (active_mask)
        );

        always #HALF_PERIOD aclk = ~aclk;

        function automatic logic [16:0] lfsr_next(input logic [16:0] s);
                return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
        endfunction

        // Two LFSR bits folded into 1..3 ticks
        task automatic pick_threshold(output logic [`MON_TIMER_W-1:0] thr);
                logic [1:0] bits;
                for (int b = 0; b < 2; b++) begin
                        bits[b] = lfsr[0];
                        lfsr    = lfsr_next(lfsr);
                end
                thr = `MON_TIMER_W'(int'(bits) % 3 + 1);
        endtask

        // Stall of threshold+1 ticks, first tick up to one period away
        function automatic int budget(input logic [`MON_TIMER_W-1:0] thr);
                return (int'(thr) + 2) * `MON_TICK_DIV + MARGIN;
        endfunction

        function automatic axi_wr_obs_t aw_word(input logic [`MON_ID_W-1:0] id, input logic rdy);
                axi_wr_obs_t o;
                o          = '0;
                o.aw_valid = 1'b1;
                o.aw_ready = rdy;
                o.aw_id    = id;
                return o;
        endfunction

        function automatic axi_wr_obs_t w_word(input logic last);
                axi_wr_obs_t o;
                o         = '0;
                o.w_valid = 1'b1;
                o.w_ready = 1'b1;
                o.w_last  = last;
                return o;
        endfunction

        function automatic axi_wr_obs_t b_word(input logic [`MON_ID_W-1:0] id);
                axi_wr_obs_t o;
                o         = '0;
                o.b_valid = 1'b1;
                o.b_ready = 1'b1;
                o.b_id    = id;
                return o;
        endfunction

        task automatic abort_run(input string msg);
                $display("%s", msg);
                $display("TEST FAILED");
                $fatal(1);
        endtask

        task automatic check_value(input string what, input int exp, input int act);
                assert (exp == act)
                else abort_run($sformatf("FAIL %s: %s expected %0d actual %0d",
                                         test_name, what, exp, act));
        endtask

        task automatic step(input axi_wr_obs_t o);
                @(posedge aclk);
                obs <= o;
        endtask

        task automatic idle(input int n);
                repeat (n) @(posedge aclk);
        endtask

        // Returns on the rising edge right after the last expected event
        task automatic await_events(input int limit);
                int n;
                n = 0;
                while (exp_q.size() != 0 && n < limit) begin
                        @(posedge aclk);
                        n++;
                end
                assert (exp_q.size() == 0)
                else abort_run($sformatf("%s: %0d event(s) still missing after %0d cycles",
                                         test_name, exp_q.size(), limit));
        endtask

        task automatic await_mask(input int id, input logic level, input int limit);
                int n;
                n = 0;
                @(negedge aclk);
                while (active_mask[id] != level && n < limit) begin
                        @(negedge aclk);
                        n++;
                end
                check_value($sformatf("active_mask[%0d]", id), level, active_mask[id]);
        endtask

        // Align to the DUT time base, returns mid-cycle of a tick
        task automatic wait_tick();
                do begin
                        @(negedge aclk);
                end while (!i_mon_top.tick);
        endtask

        // Outputs are stable at the falling edge
        always @(negedge aclk) begin
                mon_event_t want;
                if (arst_n && evt_valid) begin
                        if (exp_q.size() == 0) begin
                                abort_run($sformatf("%s: unexpected event, code %0d id %0d",
                                                    test_name, evt.code, evt.id));
                        end else begin
                                want = exp_q.pop_front();
                                check_value("event code", want.code, evt.code);
                                check_value("event id", want.id, evt.id);
                        end
                end
        end

        always @(negedge aclk) begin
                if (i_mon_top.i_mon_props.err_count != 0) begin
                        abort_run("a bound assertion on the monitor outputs failed");
                end
        end

        initial begin
                wait (budget_ready);
                repeat (2 * total_budget) @(posedge aclk);
                abort_run($sformatf("watchdog expired after %0d cycles", 2 * total_budget));
        end

        initial begin
                aclk         = 1'b0;
                arst_n       = 1'b0;
                obs          = '0;
                budget_ready = 1'b0;
                lfsr         = SEED;
                test_name    = "reset";
                pick_threshold(thr_cmd);
                pick_threshold(thr_dr);
                pick_threshold(thr_off);
                // Data and response share one threshold so both fire together
                cfg = mon_cfg_t'{addr_cnt: thr_cmd, data_cnt: thr_dr, resp_cnt: thr_dr,
                                 timeout_enable: 1'b1};
                total_budget = RST_CYCLES + 6 * SETTLE + 4 * MARGIN + budget(thr_cmd) +
                               budget(thr_dr) + budget(thr_off);
                budget_ready = 1'b1;
                repeat (RST_CYCLES) @(posedge aclk);
                arst_n <= 1'b1;
                idle(SETTLE);

                test_name = "clean_write";
                step(aw_word(2'd0, 1'b1));
                step(w_word(1'b0));
                await_mask(0, 1'b1, 2);
                step(w_word(1'b1));
                step(b_word(2'd0));
                step('0);
                await_mask(0, 1'b0, 4);
                idle(SETTLE);

                test_name = "cmd_timeout";
                exp_q.push_back(mon_event_t'{code: EVT_CMD_TIMEOUT, id: 2'd0});
                step(aw_word(2'd0, 1'b0));
                await_events(budget(thr_cmd));
                // Entry is in error now, drop AW before it goes idle
                obs <= '0;
                await_mask(0, 1'b0, 4);
                idle(SETTLE);

                test_name = "data_resp_timeout";
                exp_q.push_back(mon_event_t'{code: EVT_DATA_TIMEOUT, id: 2'd1});
                exp_q.push_back(mon_event_t'{code: EVT_RESP_TIMEOUT, id: 2'd2});
                wait_tick();
                // ID 2 finishes its data, ID 1 stops after one beat
                step(aw_word(2'd2, 1'b1));
                step(aw_word(2'd1, 1'b1) | w_word(1'b1));
                step(w_word(1'b0));
                step('0);
                await_events(budget(thr_dr));
                await_mask(1, 1'b0, 4);
                await_mask(2, 1'b0, 4);
                idle(SETTLE);

                test_name = "report_disabled";
                @(posedge aclk);
                cfg <= mon_cfg_t'{addr_cnt: thr_off, data_cnt: thr_dr, resp_cnt: thr_dr,
                                  timeout_enable: 1'b0};
                step(aw_word(2'd3, 1'b0));
                step(aw_word(2'd3, 1'b0));
                step('0);
                await_mask(3, 1'b1, 2);
                await_mask(3, 1'b0, budget(thr_off));
                idle(SETTLE);

                if (i_mon_top.i_mon_props.err_count == 0) begin
                        $display("TEST OK");
                        $finish;
                end else begin
                        abort_run("bound assertions counted errors during the run");
                end
        end

endmodule

`default_nettype wire

// File: hw/mon_bus_pkg.sv
`default_nettype none

`include "mon_macros.svh"

package mon_bus_pkg;

        // Observed write side of the AXI4 port
        typedef struct packed {
                logic                 aw_valid;
                logic                 aw_ready;
                logic [`MON_ID_W-1:0] aw_id;
                logic                 w_valid;
                logic                 w_ready;
                logic                 w_last;
                logic                 b_valid;
                logic                 b_ready;
                logic [`MON_ID_W-1:0] b_id;
                logic [1:0]           b_resp;
        } axi_wr_obs_t;

        // Lifecycle of one outstanding write
        typedef enum logic [2:0] {
                TRANS_IDLE,
                TRANS_ADDR_PHASE,
                TRANS_DATA_PHASE,
                TRANS_COMPLETE,
                TRANS_ERROR
        } trans_state_e;

        // One table word, all zero when idle
        typedef struct packed {
                logic         valid;
                trans_state_e state;
                logic         cmd_received;
                logic         data_started;
                logic         data_completed;
                logic         resp_received;
        } trans_entry_t;

        // Whole table, indexed by AXI ID
        typedef trans_entry_t [`MON_MAX_TRANS-1:0] trans_table_t;

endpackage

`default_nettype wire

// File: hw/mon_event_report.sv
`default_nettype none
`timescale 1ns/1ns

`include "mon_macros.svh"

module mon_event_report (
        input  logic                       aclk,
        input  logic                       arst_n,
        input  logic [`MON_MAX_TRANS-1:0]  timeout,
        input  mon_evt_pkg::evt_code_vec_t code,
        input  mon_evt_pkg::mon_cfg_t      cfg,
        output logic                       evt_valid,
        output mon_evt_pkg::mon_event_t    evt
);

        logic [`MON_MAX_TRANS-1:0] prev;
        logic [`MON_MAX_TRANS-1:0] pending;
        logic [`MON_MAX_TRANS-1:0] cand;
        logic [`MON_MAX_TRANS-1:0] pick;
        logic [`MON_ID_W-1:0]      sel;
        logic                      found;

        // Fresh rising bits join the pending ones
        assign cand = pending | (timeout & ~prev);

        // Lowest index wins
        always_comb begin
                sel   = '0;
                found = 1'b0;
                pick  = '0;
                for (int i = `MON_MAX_TRANS - 1; i >= 0; i--) begin
                        if (cand[i]) begin
                                sel   = `MON_ID_W'(i);
                                found = 1'b1;
                        end
                end
                pick[sel] = found;
        end

        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        prev      <= '0;
                        pending   <= '0;
                        evt_valid <= 1'b0;
                end else begin
                        prev <= timeout;
                        // Disabled means nothing reported and nothing kept
                        if (!cfg.timeout_enable) begin
                                pending   <= '0;
                                evt_valid <= 1'b0;
                        end else begin
                                pending   <= cand & ~pick;
                                evt_valid <= found;
                        end
                end
        end

        always_ff @(posedge aclk) begin
                if (found) begin
                        evt.code <= code[sel];
                        evt.id   <= sel;
                end
        end

endmodule

`default_nettype wire

// File: hw/mon_evt_pkg.sv
`default_nettype none

`include "mon_macros.svh"

package mon_evt_pkg;

        // Thresholds in ticks, plus event enable
        typedef struct packed {
                logic [`MON_TIMER_W-1:0] addr_cnt;
                logic [`MON_TIMER_W-1:0] data_cnt;
                logic [`MON_TIMER_W-1:0] resp_cnt;
                logic                    timeout_enable;
        } mon_cfg_t;

        // Phase that stalled
        typedef enum logic [1:0] {
                EVT_NONE,
                EVT_CMD_TIMEOUT,
                EVT_DATA_TIMEOUT,
                EVT_RESP_TIMEOUT
        } timeout_evt_e;

        typedef struct packed {
                timeout_evt_e         code;
                logic [`MON_ID_W-1:0] id;
        } mon_event_t;

        // Latched code per table entry
        typedef timeout_evt_e [`MON_MAX_TRANS-1:0] evt_code_vec_t;

endpackage

`default_nettype wire

// File: hw/mon_macros.svh
`ifndef MON_MACROS_SVH
`define MON_MACROS_SVH

// AXI ID width on AW and B
`define MON_ID_W 2

// Table depth, one entry per ID
`define MON_MAX_TRANS 4

// Per-phase timer width in ticks
`define MON_TIMER_W 4

// Clocks between two timer ticks
`define MON_TICK_DIV 8

`endif

// File: hw/mon_tick_gen.sv
`default_nettype none
`timescale 1ns/1ns

`include "mon_macros.svh"

module mon_tick_gen (
        input  logic aclk,
        input  logic arst_n,
        output logic tick
);

        localparam int CNT_W = $clog2(`MON_TICK_DIV);

        // Clocks left until the next tick
        logic [CNT_W-1:0] cnt;

        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        cnt  <= CNT_W'(`MON_TICK_DIV - 1);
                        tick <= 1'b0;
                end else begin
                        // One-cycle pulse when the count runs out
                        tick <= (cnt == '0);
                        if (cnt == '0) begin
                                cnt <= CNT_W'(`MON_TICK_DIV - 1);
                        end else begin
                                cnt <= cnt - 1'b1;
                        end
                end
        end

endmodule

`default_nettype wire

// File: hw/mon_timeout.sv
`default_nettype none
`timescale 1ns/1ns

`include "mon_macros.svh"

module mon_timeout (
        input  logic                       aclk,
        input  logic                       arst_n,
        input  logic                       tick,
        input  mon_bus_pkg::trans_table_t  trans_table,
        input  mon_evt_pkg::mon_cfg_t      cfg,
        output logic [`MON_MAX_TRANS-1:0]  timeout,
        output mon_evt_pkg::evt_code_vec_t code
);

        import mon_bus_pkg::*;
        import mon_evt_pkg::*;

        // Phases are address, data, response
        localparam int NPH = 3;
        localparam timeout_evt_e PHASE_CODE [NPH] = '{
                EVT_CMD_TIMEOUT,
                EVT_DATA_TIMEOUT,
                EVT_RESP_TIMEOUT
        };

        logic [`MON_TIMER_W-1:0]   tmr [`MON_MAX_TRANS][NPH];
        logic [NPH-1:0]            run [`MON_MAX_TRANS];
        logic [`MON_MAX_TRANS-1:0] live;
        logic [`MON_TIMER_W-1:0]   thr [NPH];

        assign thr[0] = cfg.addr_cnt;
        assign thr[1] = cfg.data_cnt;
        assign thr[2] = cfg.resp_cnt;

        // Which phase timers may count for each entry
        always_comb begin
                for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                        // Idle, complete and error entries are out
                        live[i] = trans_table[i].valid &&
                                  (trans_table[i].state == TRANS_ADDR_PHASE ||
                                   trans_table[i].state == TRANS_DATA_PHASE);
                        run[i][0] = live[i] && trans_table[i].state == TRANS_ADDR_PHASE &&
                                    !trans_table[i].cmd_received;
                        run[i][1] = live[i] && trans_table[i].data_started &&
                                    !trans_table[i].data_completed;
                        run[i][2] = live[i] && trans_table[i].data_completed &&
                                    !trans_table[i].resp_received;
                end
        end

        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        timeout <= '0;
                        for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                                code[i] <= EVT_NONE;
                                for (int p = 0; p < NPH; p++) begin
                                        tmr[i][p] <= '0;
                                end
                        end
                end else begin
                        for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                                // Sticky until the tracker drops the entry
                                if (!live[i]) begin
                                        timeout[i] <= 1'b0;
                                end
                                for (int p = 0; p < NPH; p++) begin
                                        if (!run[i][p]) begin
                                                tmr[i][p] <= '0;
                                        end else if (tick) begin
                                                // Compare first, then advance
                                                if (tmr[i][p] >= thr[p] && !timeout[i]) begin
                                                        timeout[i] <= 1'b1;
                                                        code[i]    <= PHASE_CODE[p];
                                                end
                                                // Saturate at full scale
                                                if (tmr[i][p] != '1) begin
                                                        tmr[i][p] <= tmr[i][p] + 1'b1;
                                                end
                                        end
                                end
                        end
                end
        end

endmodule

`default_nettype wire

// File: hw/mon_top.sv
`default_nettype none
`timescale 1ns/1ns

`include "mon_macros.svh"

module mon_top (
        input  logic                      aclk,
        input  logic                      arst_n,
        input  mon_bus_pkg::axi_wr_obs_t  obs,
        input  mon_evt_pkg::mon_cfg_t     cfg,
        output logic                      evt_valid,
        output mon_evt_pkg::mon_event_t   evt,
        output logic [`MON_MAX_TRANS-1:0] active_mask
);

        import mon_bus_pkg::*;
        import mon_evt_pkg::*;

        logic                      tick;
        trans_table_t              trans_table;
        logic [`MON_MAX_TRANS-1:0] timeout;
        evt_code_vec_t             code;

        // Time base for the phase timers
        mon_tick_gen i_tick_gen (
                .aclk   (aclk),
                .arst_n (arst_n),
                .tick   (tick)
        );

        mon_write_tracker i_tracker (
                .aclk        (aclk),
                .arst_n      (arst_n),
                .obs         (obs),
                .timeout     (timeout),
                .trans_table (trans_table),
                .active_mask (active_mask)
        );

        mon_timeout i_timeout (
                .aclk        (aclk),
                .arst_n      (arst_n),
                .tick        (tick),
                .trans_table (trans_table),
                .cfg         (cfg),
                .timeout     (timeout),
                .code        (code)
        );

        // Timeouts out as event packets
        mon_event_report i_report (
                .aclk      (aclk),
                .arst_n    (arst_n),
                .timeout   (timeout),
                .code      (code),
                .cfg       (cfg),
                .evt_valid (evt_valid),
                .evt       (evt)
        );

endmodule

`default_nettype wire

// File: hw/mon_write_tracker.sv
`default_nettype none
`timescale 1ns/1ns

`include "mon_macros.svh"

module mon_write_tracker (
        input  logic                      aclk,
        input  logic                      arst_n,
        input  mon_bus_pkg::axi_wr_obs_t  obs,
        input  logic [`MON_MAX_TRANS-1:0] timeout,
        output mon_bus_pkg::trans_table_t trans_table,
        output logic [`MON_MAX_TRANS-1:0] active_mask
);

        import mon_bus_pkg::*;

        localparam int PTR_W = $clog2(`MON_MAX_TRANS);

        // IDs with address accepted, waiting for their last W beat
        logic [`MON_ID_W-1:0] id_fifo [`MON_MAX_TRANS];
        logic [PTR_W:0]       wr_ptr;
        logic [PTR_W:0]       rd_ptr;
        logic                 fifo_empty;
        logic [`MON_ID_W-1:0] head_id;

        logic                 aw_hs;
        logic                 w_beat;
        logic                 b_hs;
        logic                 push;
        logic                 pop;

        assign aw_hs  = obs.aw_valid && obs.aw_ready;
        assign w_beat = obs.w_valid && obs.w_ready;
        assign b_hs   = obs.b_valid && obs.b_ready;

        assign fifo_empty = (wr_ptr == rd_ptr);
        assign head_id    = id_fifo[rd_ptr[PTR_W-1:0]];

        // Queue an ID once, on its AW handshake
        assign push = aw_hs && !timeout[obs.aw_id] &&
                      !trans_table[obs.aw_id].cmd_received;

        // Head leaves on its last beat
        // Only the head can hit a data timeout, so drop it then as well
        assign pop = !fifo_empty && ((w_beat && obs.w_last) || timeout[head_id]);

        always_ff @(posedge aclk) begin
                if (push) begin
                        id_fifo[wr_ptr[PTR_W-1:0]] <= obs.aw_id;
                end
        end

        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (push) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (pop) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                end
        end

        // Per-entry FSM
        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        trans_table <= '0;
                end else begin
                        for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                                case (trans_table[i].state)
                                // Retire one clock after completion or timeout
                                TRANS_COMPLETE, TRANS_ERROR: begin
                                        trans_table[i] <= '0;
                                end
                                default: begin
                                        if (timeout[i]) begin
                                                trans_table[i].state <= TRANS_ERROR;
                                        end else begin
                                                // New write on an idle ID
                                                if (obs.aw_valid &&
                                                    obs.aw_id == `MON_ID_W'(i) &&
                                                    trans_table[i].state == TRANS_IDLE) begin
                                                        trans_table[i].valid <= 1'b1;
                                                        trans_table[i].state <= TRANS_ADDR_PHASE;
                                                end
                                                if (aw_hs && obs.aw_id == `MON_ID_W'(i)) begin
                                                        trans_table[i].cmd_received <= 1'b1;
                                                end
                                                // W beat goes to the queue head
                                                if (w_beat && !fifo_empty &&
                                                    head_id == `MON_ID_W'(i)) begin
                                                        trans_table[i].data_started <= 1'b1;
                                                        trans_table[i].state <= TRANS_DATA_PHASE;
                                                        if (obs.w_last) begin
                                                                trans_table[i].data_completed <= 1'b1;
                                                        end
                                                end
                                                // Response closes the entry
                                                if (b_hs && obs.b_id == `MON_ID_W'(i) &&
                                                    trans_table[i].valid) begin
                                                        trans_table[i].resp_received <= 1'b1;
                                                        trans_table[i].state <= TRANS_COMPLETE;
                                                end
                                        end
                                end
                                endcase
                        end
                end
        end

        always_comb begin
                for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                        active_mask[i] = trans_table[i].valid;
                end
        end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the AXI write monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
if ! verilator --binary --assert --timing -Wno-fatal --top-module mon_tb -f vlog.f -o mon_sim
then
        echo "verilator build failed"
        exit 1
fi

./obj_dir/mon_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
        echo "simulation reported failure"
        exit 1
fi
if [ "$status" -ne 0 ]; then
        echo "simulator exited with status $status"
        exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
        echo "simulation ended without a result"
        exit 1
fi
exit 0

// File: vlog.f
+incdir+hw
hw/mon_bus_pkg.sv
hw/mon_evt_pkg.sv
hw/mon_tick_gen.sv
hw/mon_write_tracker.sv
hw/mon_timeout.sv
hw/mon_event_report.sv
hw/mon_top.sv
dv/mon_props.sv
dv/mon_tb.sv
